//--- verilog/pe_ctrl_macros.svh
`ifndef PE_CTRL_MACROS_SVH
`define PE_CTRL_MACROS_SVH

//----------------------------------------------------------------------
// instruction word geometry
//----------------------------------------------------------------------

`define PE_FN_LEN 3
`define PE_NAME_LEN 3
`define PE_INDEX_LEN 8

// destination and source slots per word
`define PE_SLOTS 3

//----------------------------------------------------------------------
// memory address widths
//----------------------------------------------------------------------

// gradient memory shares this width
`define PE_WEIGHT_ADDR_LEN 5
`define PE_DATA_ADDR_LEN 5
`define PE_INTERIM_ADDR_LEN 2
`define PE_META_ADDR_LEN 2

//----------------------------------------------------------------------
// namespace codes
//----------------------------------------------------------------------

// zero marks an empty slot
`define PE_NS_NONE 3'd0
`define PE_NS_DATA 3'd1
`define PE_NS_WEIGHT 3'd2
`define PE_NS_GRADIENT 3'd3
`define PE_NS_INTERIM 3'd4
`define PE_NS_META 3'd5
`define PE_NS_NEIGHBOR 3'd6
`define PE_NS_BUS 3'd7

`endif

//--- verilog/pe_ctrl_pkg.sv
`include "pe_ctrl_macros.svh"

package pe_ctrl_pkg;

	//------------------------------------------------------------------
	// field widths
	//------------------------------------------------------------------

	typedef logic [`PE_FN_LEN-1:0] fn_t;
	typedef logic [`PE_NAME_LEN-1:0] ns_name_t;
	typedef logic [`PE_INDEX_LEN-1:0] slot_index_t;

	typedef logic [`PE_WEIGHT_ADDR_LEN-1:0] weight_addr_t;
	typedef logic [`PE_DATA_ADDR_LEN-1:0] data_addr_t;
	typedef logic [`PE_INTERIM_ADDR_LEN-1:0] interim_addr_t;
	typedef logic [`PE_META_ADDR_LEN-1:0] meta_addr_t;

	//------------------------------------------------------------------
	// instruction word with msb first
	//------------------------------------------------------------------

	typedef struct packed {
		ns_name_t    name;
		slot_index_t index;
	} inst_slot_t;

	// 3 + 6 * 11 = 69 bits
	typedef struct packed {
		fn_t        fn;
		inst_slot_t dest0;
		inst_slot_t dest1;
		inst_slot_t dest2;
		inst_slot_t src0;
		inst_slot_t src1;
		inst_slot_t src2;
	} inst_word_t;

	//------------------------------------------------------------------
	// decoded controls
	//------------------------------------------------------------------

	// write side seen two cycles after acceptance
	typedef struct packed {
		fn_t           fn;
		logic          weight_wrt;
		logic          gradient_wrt;
		logic          interim_wrt;
		weight_addr_t  weight_wrt_addr;
		weight_addr_t  gradient_wrt_addr;
		interim_addr_t interim_wrt_addr;
		logic          pe_neigh_wrt;
		logic          pu_neigh_wrt;
		slot_index_t   pe_bus_wrt_addr;
		slot_index_t   gb_bus_wrt_addr;
		logic          eol;
		logic          valid;
	} wr_ctrl_t;

	// early read addresses one cycle ahead for the block RAMs
	typedef struct packed {
		data_addr_t   data_rd_addr;
		weight_addr_t weight_rd_addr;
		weight_addr_t gradient_rd_addr;
		meta_addr_t   meta_rd_addr;
	} rd_addr_t;

	// read side on the slow path
	typedef struct packed {
		interim_addr_t                   interim_rd_addr;
		logic                            pe_neigh_rq;
		logic                            pu_neigh_rq;
		logic                            pe_bus_rq;
		logic                            gb_bus_rq;
		logic [`PE_SLOTS-1:0]            src_rq;
		ns_name_t [`PE_SLOTS-1:0]        src_name;
		slot_index_t [`PE_SLOTS-1:0]     src_index;
	} src_ctrl_t;

endpackage

//--- verilog/dest_write_decode.sv
`timescale 1ns/1ps

`include "pe_ctrl_macros.svh"

module dest_write_decode
(
	input  pe_ctrl_pkg::fn_t        fn,
	input  pe_ctrl_pkg::inst_slot_t dest [`PE_SLOTS],
	input  pe_ctrl_pkg::ns_name_t   src_names [`PE_SLOTS],
	input  logic                    inst_v,
	output pe_ctrl_pkg::wr_ctrl_t   wr_next
);

	import pe_ctrl_pkg::*;

	// hits or-reduced over the three destinations
	logic weight_hit;
	logic gradient_hit;
	logic interim_hit;
	logic pe_neigh_hit;
	logic pu_neigh_hit;
	logic pe_bus_hit;
	logic gb_bus_hit;

	weight_addr_t  weight_addr;
	weight_addr_t  gradient_addr;
	interim_addr_t interim_addr;

	// bus index without the select bit
	logic [`PE_INDEX_LEN-1:1] bus_upper;

	logic names_used;

	//------------------------------------------------------------------
	// slot matching
	//------------------------------------------------------------------

	always_comb
	begin
		weight_hit    = 1'b0;
		gradient_hit  = 1'b0;
		interim_hit   = 1'b0;
		pe_neigh_hit  = 1'b0;
		pu_neigh_hit  = 1'b0;
		pe_bus_hit    = 1'b0;
		gb_bus_hit    = 1'b0;
		weight_addr   = '0;
		gradient_addr = '0;
		interim_addr  = '0;
		bus_upper     = '0;

		for (int i = 0; i < `PE_SLOTS; i++)
		begin
			case (dest[i].name)
				`PE_NS_WEIGHT:
				begin
					weight_hit  = 1'b1;
					weight_addr |= dest[i].index[`PE_WEIGHT_ADDR_LEN-1:0];
				end
				`PE_NS_GRADIENT:
				begin
					gradient_hit  = 1'b1;
					gradient_addr |= dest[i].index[`PE_WEIGHT_ADDR_LEN-1:0];
				end
				`PE_NS_INTERIM:
				begin
					interim_hit  = 1'b1;
					interim_addr |= dest[i].index[`PE_INTERIM_ADDR_LEN-1:0];
				end
				// bit 0 picks own PE or the PU neighbour
				`PE_NS_NEIGHBOR:
				begin
					if (dest[i].index[0])
						pu_neigh_hit = 1'b1;
					else
						pe_neigh_hit = 1'b1;
				end
				// bit 0 picks PE bus or global bus
				`PE_NS_BUS:
				begin
					bus_upper |= dest[i].index[`PE_INDEX_LEN-1:1];
					if (dest[i].index[0])
						gb_bus_hit = 1'b1;
					else
						pe_bus_hit = 1'b1;
				end
				default:
				begin
				end
			endcase
		end
	end

	//------------------------------------------------------------------
	// end of list
	//------------------------------------------------------------------

	// any destination or source slot in use
	always_comb
	begin
		names_used = 1'b0;
		for (int i = 0; i < `PE_SLOTS; i++)
		begin
			if (dest[i].name != `PE_NS_NONE || src_names[i] != `PE_NS_NONE)
				names_used = 1'b1;
		end
	end

	//------------------------------------------------------------------
	// output struct
	//------------------------------------------------------------------

	always_comb
	begin
		wr_next.fn                = fn;
		wr_next.weight_wrt        = weight_hit & inst_v;
		wr_next.gradient_wrt      = gradient_hit & inst_v;
		wr_next.interim_wrt       = interim_hit & inst_v;
		wr_next.weight_wrt_addr   = weight_addr;
		wr_next.gradient_wrt_addr = gradient_addr;
		wr_next.interim_wrt_addr  = interim_addr;
		wr_next.pe_neigh_wrt      = pe_neigh_hit & inst_v;
		wr_next.pu_neigh_wrt      = pu_neigh_hit & inst_v;
		// low bit of each bus address carries that bus's write flag
		wr_next.pe_bus_wrt_addr   = {bus_upper, pe_bus_hit & inst_v};
		wr_next.gb_bus_wrt_addr   = {bus_upper, gb_bus_hit & inst_v};
		wr_next.eol               = ~names_used & inst_v;
		wr_next.valid             = inst_v;
	end

endmodule

//--- verilog/src_read_decode.sv
`timescale 1ns/1ps

`include "pe_ctrl_macros.svh"

module src_read_decode
(
	input  pe_ctrl_pkg::inst_slot_t src [`PE_SLOTS],
	input  logic                    inst_v,
	output pe_ctrl_pkg::rd_addr_t   rd_next,
	output pe_ctrl_pkg::src_ctrl_t  src_next
);

	import pe_ctrl_pkg::*;

	// fast path addresses
	data_addr_t   data_addr;
	weight_addr_t weight_addr;
	weight_addr_t gradient_addr;
	meta_addr_t   meta_addr;

	// interim memory is not a block RAM so its address takes the slow path
	interim_addr_t interim_addr;

	logic pe_neigh_hit;
	logic pu_neigh_hit;
	logic pe_bus_hit;
	logic gb_bus_hit;

	//------------------------------------------------------------------
	// slot matching
	//------------------------------------------------------------------

	always_comb
	begin
		data_addr     = '0;
		weight_addr   = '0;
		gradient_addr = '0;
		meta_addr     = '0;
		interim_addr  = '0;
		pe_neigh_hit  = 1'b0;
		pu_neigh_hit  = 1'b0;
		pe_bus_hit    = 1'b0;
		gb_bus_hit    = 1'b0;

		for (int i = 0; i < `PE_SLOTS; i++)
		begin
			case (src[i].name)
				`PE_NS_DATA:
					data_addr |= src[i].index[`PE_DATA_ADDR_LEN-1:0];
				`PE_NS_WEIGHT:
					weight_addr |= src[i].index[`PE_WEIGHT_ADDR_LEN-1:0];
				`PE_NS_GRADIENT:
					gradient_addr |= src[i].index[`PE_WEIGHT_ADDR_LEN-1:0];
				`PE_NS_META:
					meta_addr |= src[i].index[`PE_META_ADDR_LEN-1:0];
				`PE_NS_INTERIM:
					interim_addr |= src[i].index[`PE_INTERIM_ADDR_LEN-1:0];
				`PE_NS_NEIGHBOR:
				begin
					if (src[i].index[0])
						pu_neigh_hit = 1'b1;
					else
						pe_neigh_hit = 1'b1;
				end
				`PE_NS_BUS:
				begin
					if (src[i].index[0])
						gb_bus_hit = 1'b1;
					else
						pe_bus_hit = 1'b1;
				end
				default:
				begin
				end
			endcase
		end
	end

	//------------------------------------------------------------------
	// outputs
	//------------------------------------------------------------------

	always_comb
	begin
		rd_next.data_rd_addr     = data_addr;
		rd_next.weight_rd_addr   = weight_addr;
		rd_next.gradient_rd_addr = gradient_addr;
		rd_next.meta_rd_addr     = meta_addr;
	end

	always_comb
	begin
		src_next.interim_rd_addr = interim_addr;
		src_next.pe_neigh_rq     = pe_neigh_hit & inst_v;
		src_next.pu_neigh_rq     = pu_neigh_hit & inst_v;
		src_next.pe_bus_rq       = pe_bus_hit & inst_v;
		src_next.gb_bus_rq       = gb_bus_hit & inst_v;

		// names and indexes ride along for the PE core operand mux
		for (int i = 0; i < `PE_SLOTS; i++)
		begin
			src_next.src_rq[i]    = (src[i].name != `PE_NS_NONE) & inst_v;
			src_next.src_name[i]  = src[i].name;
			src_next.src_index[i] = src[i].index;
		end
	end

endmodule

//--- verilog/ctrl_delay_line.sv
`timescale 1ns/1ps

module ctrl_delay_line
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   advance,
	input  pe_ctrl_pkg::wr_ctrl_t  wr_next,
	input  pe_ctrl_pkg::rd_addr_t  rd_next,
	input  pe_ctrl_pkg::src_ctrl_t src_next,
	output pe_ctrl_pkg::wr_ctrl_t  wr,
	output pe_ctrl_pkg::rd_addr_t  rd,
	output pe_ctrl_pkg::src_ctrl_t src
);

	import pe_ctrl_pkg::*;

	// first stage of the two-cycle paths
	wr_ctrl_t  wr_mid;
	src_ctrl_t src_mid;

	//------------------------------------------------------------------
	// read address stage
	//------------------------------------------------------------------

	// the block RAMs take one cycle to return data, so the
	// addresses leave one stage earlier than the rest
	always_ff @(posedge clk)
	begin
		if (reset)
			rd <= '0;
		else if (advance)
			rd <= rd_next;
	end

	//------------------------------------------------------------------
	// write controls, two stages
	//------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_mid <= '0;
			wr     <= '0;
		end
		else if (advance)
		begin
			wr_mid <= wr_next;
			wr     <= wr_mid;
		end
	end

	//------------------------------------------------------------------
	// source controls, two stages
	//------------------------------------------------------------------

	// lines up with the read data coming back from the block RAMs
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			src_mid <= '0;
			src     <= '0;
		end
		else if (advance)
		begin
			src_mid <= src_next;
			src     <= src_mid;
		end
	end

endmodule

//--- verilog/pe_controller.sv
`timescale 1ns/1ps

`include "pe_ctrl_macros.svh"

module pe_controller
(
	input  logic                    clk,
	input  logic                    reset,
	input  pe_ctrl_pkg::inst_word_t inst_in,
	input  logic                    inst_in_v,
	input  logic                    inst_stall,
	input  logic                    bus_contention,
	output pe_ctrl_pkg::wr_ctrl_t   wr,
	output pe_ctrl_pkg::rd_addr_t   rd,
	output pe_ctrl_pkg::src_ctrl_t  src
);

	import pe_ctrl_pkg::*;

	inst_slot_t dest_slot [`PE_SLOTS];
	inst_slot_t src_slot [`PE_SLOTS];
	ns_name_t   src_name [`PE_SLOTS];

	wr_ctrl_t  wr_next;
	rd_addr_t  rd_next;
	src_ctrl_t src_next;

	logic advance;

	//------------------------------------------------------------------
	// instruction split
	//------------------------------------------------------------------

	assign dest_slot[0] = inst_in.dest0;
	assign dest_slot[1] = inst_in.dest1;
	assign dest_slot[2] = inst_in.dest2;

	assign src_slot[0] = inst_in.src0;
	assign src_slot[1] = inst_in.src1;
	assign src_slot[2] = inst_in.src2;

	// source names also feed end-of-list
	assign src_name[0] = inst_in.src0.name;
	assign src_name[1] = inst_in.src1.name;
	assign src_name[2] = inst_in.src2.name;

	// pipeline moves only when nothing holds it
	assign advance = ~(inst_stall | bus_contention);

	//------------------------------------------------------------------
	// decoders and pipeline
	//------------------------------------------------------------------

	dest_write_decode i_dest_write_decode (
		.fn        (inst_in.fn),
		.dest      (dest_slot),
		.src_names (src_name),
		.inst_v    (inst_in_v),
		.wr_next   (wr_next)
	);

	src_read_decode i_src_read_decode (
		.src      (src_slot),
		.inst_v   (inst_in_v),
		.rd_next  (rd_next),
		.src_next (src_next)
	);

	ctrl_delay_line i_ctrl_delay_line (
		.clk      (clk),
		.reset    (reset),
		.advance  (advance),
		.wr_next  (wr_next),
		.rd_next  (rd_next),
		.src_next (src_next),
		.wr       (wr),
		.rd       (rd),
		.src      (src)
	);

endmodule

//--- tests/pe_controller_tb.sv
`timescale 1ns/1ps

`include "pe_ctrl_macros.svh"

module pe_controller_tb;

	import pe_ctrl_pkg::*;

	localparam int RESET_CYCLES = 10;
	// upper bounds on the words driven and the cycles each one takes
	localparam int NUM_WORDS = 32;
	localparam int WORD_CYCLES = 2;
	localparam int STALL_TEST_CYCLES = 12;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_WORDS * WORD_CYCLES
		+ 2 * STALL_TEST_CYCLES + 200;

	logic        clk;
	logic        reset;
	inst_word_t  inst_in;
	logic        inst_in_v;
	logic        inst_stall;
	logic        bus_contention;
	wr_ctrl_t    wr;
	rd_addr_t    rd;
	src_ctrl_t   src;
	int          wr_errors;
	int          rd_errors;
	int          src_errors;
	int          cycle_count;
	logic [31:0] rng_state;

	pe_controller i_dut (
		.clk            (clk),
		.reset          (reset),
		.inst_in        (inst_in),
		.inst_in_v      (inst_in_v),
		.inst_stall     (inst_stall),
		.bus_contention (bus_contention),
		.wr             (wr),
		.rd             (rd),
		.src            (src)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	//----------------------------------------------------------------------
	// random numbers and word building
	//----------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic fn_t rand_fn();
		logic [31:0] r;
		r = next_rand();
		return r[`PE_FN_LEN-1:0];
	endfunction

	function automatic slot_index_t rand_index();
		logic [31:0] r;
		r = next_rand();
		return r[`PE_INDEX_LEN-1:0];
	endfunction

	function automatic inst_slot_t make_slot(input ns_name_t ns, input slot_index_t idx);
		inst_slot_t s;
		s.name = ns;
		s.index = idx;
		return s;
	endfunction

	// word with a single active slot
	function automatic inst_word_t one_slot_word(input fn_t fn, input logic to_src,
		input int pos, input ns_name_t ns, input slot_index_t idx);
		inst_word_t w;
		inst_slot_t s;
		w = '0;
		w.fn = fn;
		s = make_slot(ns, idx);
		if (to_src)
		begin
			case (pos)
				0: w.src0 = s;
				1: w.src1 = s;
				default: w.src2 = s;
			endcase
		end
		else
		begin
			case (pos)
				0: w.dest0 = s;
				1: w.dest1 = s;
				default: w.dest2 = s;
			endcase
		end
		return w;
	endfunction

	//----------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------

	function automatic inst_slot_t slot_of(input inst_word_t w, input logic from_src,
		input int i);
		case (i)
			0: return from_src ? w.src0 : w.dest0;
			1: return from_src ? w.src1 : w.dest1;
			default: return from_src ? w.src2 : w.dest2;
		endcase
	endfunction

	// or of the indexes of every slot carrying this name
	function automatic slot_index_t merged_index(input inst_word_t w, input logic from_src,
		input ns_name_t ns);
		slot_index_t acc;
		inst_slot_t s;
		acc = '0;
		for (int i = 0; i < `PE_SLOTS; i++)
		begin
			s = slot_of(w, from_src, i);
			if (s.name == ns)
				acc = acc | s.index;
		end
		return acc;
	endfunction

	// some slot has this name, and with match_sel also this select bit
	function automatic logic slot_seen(input inst_word_t w, input logic from_src,
		input ns_name_t ns, input logic match_sel, input logic sel);
		inst_slot_t s;
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < `PE_SLOTS; i++)
		begin
			s = slot_of(w, from_src, i);
			if (s.name == ns && (!match_sel || s.index[0] == sel))
				seen = 1'b1;
		end
		return seen;
	endfunction

	function automatic wr_ctrl_t model_wr(input inst_word_t w, input logic v);
		wr_ctrl_t m;
		slot_index_t wt;
		slot_index_t gr;
		slot_index_t im;
		slot_index_t bus;
		logic all_empty;
		wt = merged_index(w, 1'b0, `PE_NS_WEIGHT);
		gr = merged_index(w, 1'b0, `PE_NS_GRADIENT);
		im = merged_index(w, 1'b0, `PE_NS_INTERIM);
		bus = merged_index(w, 1'b0, `PE_NS_BUS);
		all_empty = w.dest0.name == `PE_NS_NONE && w.dest1.name == `PE_NS_NONE
			&& w.dest2.name == `PE_NS_NONE && w.src0.name == `PE_NS_NONE
			&& w.src1.name == `PE_NS_NONE && w.src2.name == `PE_NS_NONE;
		m = '0;
		m.fn = w.fn;
		m.weight_wrt = v & slot_seen(w, 1'b0, `PE_NS_WEIGHT, 1'b0, 1'b0);
		m.gradient_wrt = v & slot_seen(w, 1'b0, `PE_NS_GRADIENT, 1'b0, 1'b0);
		m.interim_wrt = v & slot_seen(w, 1'b0, `PE_NS_INTERIM, 1'b0, 1'b0);
		m.weight_wrt_addr = wt[`PE_WEIGHT_ADDR_LEN-1:0];
		m.gradient_wrt_addr = gr[`PE_WEIGHT_ADDR_LEN-1:0];
		m.interim_wrt_addr = im[`PE_INTERIM_ADDR_LEN-1:0];
		m.pe_neigh_wrt = v & slot_seen(w, 1'b0, `PE_NS_NEIGHBOR, 1'b1, 1'b0);
		m.pu_neigh_wrt = v & slot_seen(w, 1'b0, `PE_NS_NEIGHBOR, 1'b1, 1'b1);
		m.pe_bus_wrt_addr = {bus[`PE_INDEX_LEN-1:1],
			v & slot_seen(w, 1'b0, `PE_NS_BUS, 1'b1, 1'b0)};
		m.gb_bus_wrt_addr = {bus[`PE_INDEX_LEN-1:1],
			v & slot_seen(w, 1'b0, `PE_NS_BUS, 1'b1, 1'b1)};
		m.eol = v & all_empty;
		m.valid = v;
		return m;
	endfunction

	function automatic rd_addr_t model_rd(input inst_word_t w);
		rd_addr_t m;
		slot_index_t da;
		slot_index_t wt;
		slot_index_t gr;
		slot_index_t me;
		da = merged_index(w, 1'b1, `PE_NS_DATA);
		wt = merged_index(w, 1'b1, `PE_NS_WEIGHT);
		gr = merged_index(w, 1'b1, `PE_NS_GRADIENT);
		me = merged_index(w, 1'b1, `PE_NS_META);
		m.data_rd_addr = da[`PE_DATA_ADDR_LEN-1:0];
		m.weight_rd_addr = wt[`PE_WEIGHT_ADDR_LEN-1:0];
		m.gradient_rd_addr = gr[`PE_WEIGHT_ADDR_LEN-1:0];
		m.meta_rd_addr = me[`PE_META_ADDR_LEN-1:0];
		return m;
	endfunction

	function automatic src_ctrl_t model_src(input inst_word_t w, input logic v);
		src_ctrl_t m;
		slot_index_t im;
		im = merged_index(w, 1'b1, `PE_NS_INTERIM);
		m.interim_rd_addr = im[`PE_INTERIM_ADDR_LEN-1:0];
		m.pe_neigh_rq = v & slot_seen(w, 1'b1, `PE_NS_NEIGHBOR, 1'b1, 1'b0);
		m.pu_neigh_rq = v & slot_seen(w, 1'b1, `PE_NS_NEIGHBOR, 1'b1, 1'b1);
		m.pe_bus_rq = v & slot_seen(w, 1'b1, `PE_NS_BUS, 1'b1, 1'b0);
		m.gb_bus_rq = v & slot_seen(w, 1'b1, `PE_NS_BUS, 1'b1, 1'b1);
		m.src_rq = {w.src2.name != `PE_NS_NONE, w.src1.name != `PE_NS_NONE,
			w.src0.name != `PE_NS_NONE} & {`PE_SLOTS{v}};
		m.src_name = {w.src2.name, w.src1.name, w.src0.name};
		m.src_index = {w.src2.index, w.src1.index, w.src0.index};
		return m;
	endfunction

	//----------------------------------------------------------------------
	// checks
	//----------------------------------------------------------------------

	task automatic check_wr(input string name, input wr_ctrl_t exp, input wr_ctrl_t act);
		if (act !== exp)
		begin
			wr_errors++;
			$display("MISMATCH %s wr expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_rd(input string name, input rd_addr_t exp, input rd_addr_t act);
		if (act !== exp)
		begin
			rd_errors++;
			$display("MISMATCH %s rd expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_src(input string name, input src_ctrl_t exp,
		input src_ctrl_t act);
		if (act !== exp)
		begin
			src_errors++;
			$display("MISMATCH %s src expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic print_counts();
		$display("errors wr %0d rd %0d src %0d", wr_errors, rd_errors, src_errors);
	endtask

	//----------------------------------------------------------------------
	// tests entered 1 ns after a rising edge
	//----------------------------------------------------------------------

	// one word with rd after one edge and wr and src after two
	task automatic apply_word(input string name, input inst_word_t w, input logic v);
		inst_in = w;
		inst_in_v = v;
		@(posedge clk);
		#1;
		inst_in = '0;
		inst_in_v = 1'b0;
		check_rd(name, model_rd(w), rd);
		@(posedge clk);
		#1;
		check_wr(name, model_wr(w, v), wr);
		check_src(name, model_src(w, v), src);
	endtask

	task automatic run_word(input string name, input inst_word_t w);
		apply_word(name, w, 1'b1);
	endtask

	task automatic test_reset();
		check_wr("reset", '0, wr);
		check_rd("reset", '0, rd);
		check_src("reset", '0, src);
	endtask

	task automatic test_mem_writes();
		ns_name_t kinds [3];
		kinds[0] = `PE_NS_WEIGHT;
		kinds[1] = `PE_NS_GRADIENT;
		kinds[2] = `PE_NS_INTERIM;
		for (int k = 0; k < 3; k++)
		begin
			for (int i = 0; i < `PE_SLOTS; i++)
				run_word("mem_write", one_slot_word(rand_fn(), 1'b0, i, kinds[k],
					rand_index()));
		end
	endtask

	task automatic test_bus_neigh_writes();
		inst_word_t w;
		slot_index_t idx;
		for (int n = 0; n < 4; n++)
		begin
			idx = rand_index();
			idx[0] = n[0];
			run_word("bus_neigh_write", one_slot_word(rand_fn(), 1'b0, n % 3,
				n[1] ? `PE_NS_BUS : `PE_NS_NEIGHBOR, idx));
		end
		// both neighbour strobes from one word
		w = one_slot_word(rand_fn(), 1'b0, 0, `PE_NS_NEIGHBOR, 8'h10);
		w.dest2 = make_slot(`PE_NS_NEIGHBOR, 8'h21);
		run_word("bus_neigh_write", w);
	endtask

	task automatic test_mem_reads();
		ns_name_t kinds [5];
		inst_word_t w;
		kinds[0] = `PE_NS_DATA;
		kinds[1] = `PE_NS_WEIGHT;
		kinds[2] = `PE_NS_GRADIENT;
		kinds[3] = `PE_NS_META;
		kinds[4] = `PE_NS_INTERIM;
		for (int k = 0; k < 5; k++)
			run_word("mem_read", one_slot_word(rand_fn(), 1'b1, k % 3, kinds[k],
				rand_index()));
		// two data sources merge into one address
		w = one_slot_word(rand_fn(), 1'b1, 0, `PE_NS_DATA, rand_index());
		w.src1 = make_slot(`PE_NS_WEIGHT, rand_index());
		w.src2 = make_slot(`PE_NS_DATA, rand_index());
		run_word("mem_read", w);
	endtask

	task automatic test_src_requests();
		slot_index_t idx;
		for (int n = 0; n < 4; n++)
		begin
			idx = rand_index();
			idx[0] = n[0];
			run_word("src_request", one_slot_word(rand_fn(), 1'b1, (n + 1) % 3,
				n[1] ? `PE_NS_BUS : `PE_NS_NEIGHBOR, idx));
		end
		run_word("eol_empty", one_slot_word(rand_fn(), 1'b0, 0, `PE_NS_NONE, 8'h00));
		run_word("eol_one_dest", one_slot_word(rand_fn(), 1'b0, 2, `PE_NS_WEIGHT,
			rand_index()));
	endtask

	// valid low with active slots drops every strobe, flag and request
	task automatic test_invalid_words();
		inst_word_t w;
		slot_index_t idx;
		for (int n = 0; n < 2; n++)
		begin
			idx = rand_index();
			idx[0] = n[0];
			w = one_slot_word(rand_fn(), 1'b0, 0, `PE_NS_BUS, idx);
			w.dest1 = make_slot(n[0] ? `PE_NS_GRADIENT : `PE_NS_WEIGHT, rand_index());
			w.dest2 = make_slot(n[0] ? `PE_NS_NEIGHBOR : `PE_NS_INTERIM, rand_index());
			w.src0 = make_slot(`PE_NS_NEIGHBOR, idx);
			w.src1 = make_slot(`PE_NS_BUS, idx);
			w.src2 = make_slot(`PE_NS_INTERIM, rand_index());
			apply_word("invalid_word", w, 1'b0);
		end
	endtask

	// two words in flight held three cycles and then drained
	task automatic test_stall(input string name, input logic use_contention);
		inst_word_t wa;
		inst_word_t wb;
		inst_word_t wd;
		wa = one_slot_word(rand_fn(), 1'b0, 0, `PE_NS_WEIGHT, rand_index());
		wa.src1 = make_slot(`PE_NS_DATA, rand_index());
		wb = one_slot_word(rand_fn(), 1'b0, 1, `PE_NS_GRADIENT, rand_index());
		wb.src2 = make_slot(`PE_NS_META, rand_index());
		wb.src0 = make_slot(`PE_NS_INTERIM, rand_index());
		wd = one_slot_word(rand_fn(), 1'b0, 2, `PE_NS_INTERIM, rand_index());
		wd.src0 = make_slot(`PE_NS_BUS, rand_index());
		wd.src1 = make_slot(`PE_NS_DATA, 8'h1f);
		inst_in = wa;
		inst_in_v = 1'b1;
		@(posedge clk);
		#1;
		inst_in = wb;
		@(posedge clk);
		#1;
		check_rd(name, model_rd(wb), rd);
		check_wr(name, model_wr(wa, 1'b1), wr);
		check_src(name, model_src(wa, 1'b1), src);
		// wd arrives during the hold and must be dropped
		inst_in = wd;
		if (use_contention)
			bus_contention = 1'b1;
		else
			inst_stall = 1'b1;
		repeat (3)
		begin
			@(posedge clk);
			#1;
			check_rd(name, model_rd(wb), rd);
			check_wr(name, model_wr(wa, 1'b1), wr);
			check_src(name, model_src(wa, 1'b1), src);
		end
		inst_stall = 1'b0;
		bus_contention = 1'b0;
		inst_in = '0;
		inst_in_v = 1'b0;
		@(posedge clk);
		#1;
		check_rd(name, model_rd('0), rd);
		check_wr(name, model_wr(wb, 1'b1), wr);
		check_src(name, model_src(wb, 1'b1), src);
		@(posedge clk);
		#1;
		check_wr(name, model_wr('0, 1'b0), wr);
		check_src(name, model_src('0, 1'b0), src);
	endtask

	//----------------------------------------------------------------------
	// sequence and timeout
	//----------------------------------------------------------------------

	initial
	begin
		rng_state = 32'd31;
		wr_errors = 0;
		rd_errors = 0;
		src_errors = 0;
		reset = 1'b1;
		inst_in = '0;
		inst_in_v = 1'b0;
		inst_stall = 1'b0;
		bus_contention = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_mem_writes();
		test_bus_neigh_writes();
		test_mem_reads();
		test_src_requests();
		test_invalid_words();
		test_stall("stall_inst", 1'b0);
		test_stall("stall_bus", 1'b1);
		print_counts();
		if (wr_errors + rd_errors + src_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		print_counts();
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- all.f
+incdir+verilog
verilog/pe_ctrl_pkg.sv
verilog/dest_write_decode.sv
verilog/src_read_decode.sv
verilog/ctrl_delay_line.sv
verilog/pe_controller.sv
tests/pe_controller_tb.sv

//--- Bender.yml
package:
  name: pe_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pe_ctrl_pkg.sv
      - verilog/dest_write_decode.sv
      - verilog/src_read_decode.sv
      - verilog/ctrl_delay_line.sv
      - verilog/pe_controller.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/pe_controller_tb.sv
